//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module attn_tb -Mdir obj_dir -f flist.f
	@out="$$(./obj_dir/Vattn_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- flist.f
hdl/attn_pkg.sv
hdl/attn_cfg_regs.sv
hdl/tile_mem.sv
hdl/mat_mult_array.sv
hdl/row_softmax.sv
hdl/attn_ctrl.sv
hdl/attn_top.sv
verification/attn_ctrl_chk.sv
verification/attn_tb.sv

//--- hdl/attn_cfg_regs.sv
module attn_cfg_regs
    import attn_pkg::*;
(
    input  logic I_CLK,
    input  logic I_RST_N,
    input  logic i_cfg_wr,
    input  cfg_t i_cfg_data,
    input  logic i_busy,
    output cfg_t o_cfg
);

    // the value stays frozen for the whole run, softmax reads it live
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            o_cfg <= '0;
        end else if (i_cfg_wr && !i_busy) begin
            o_cfg <= i_cfg_data;  // locked while a run is going
        end
    end

endmodule

//--- hdl/attn_ctrl.sv
module attn_ctrl
    import attn_pkg::*;
(
    input  logic       I_CLK,
    input  logic       I_RST_N,
    input  logic       i_start,
    output logic       o_busy,
    output logic       o_rd_en,
    output mat_sel_t   o_rd_sel,
    input  logic       i_rd_vld,
    input  elem_tile_t i_rd_tile,
    output logic       o_mm_start,
    output op_tile_t   o_mm_a,
    output op_tile_t   o_mm_b,
    input  logic       i_mm_done,
    input  acc_tile_t  i_mm_result,
    output logic       o_sm_start,
    output acc_tile_t  o_sm_scores,
    input  logic       i_sm_done,
    input  prob_tile_t i_sm_probs,
    output logic       o_att_vld,
    output out_tile_t  o_att_tile
);

    ctrl_state_t state;
    op_tile_t    k_op;       // K kept as the b operand of Q*K^T
    prob_tile_t  p_q;        // softmax result kept for P*V
    op_tile_t    rd_sext;
    op_tile_t    rd_sext_t;  // transposed read tile, V as b operand
    op_tile_t    p_zext;
    out_tile_t   att_next;

    //////////////////////////////////////////////////////////////////////
    // operand forming
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                rd_sext[i][j]   = {i_rd_tile[i][j][ELEM_W-1], i_rd_tile[i][j]};
                rd_sext_t[j][i] = {i_rd_tile[i][j][ELEM_W-1], i_rd_tile[i][j]};
                p_zext[i][j]    = {1'b0, p_q[i][j]};
            end
        end
    end

    always_comb begin
        acc_t acc_v;
        for (int i = 0; i < TILE; i++) begin
            for (int c = 0; c < TILE; c++) begin
                acc_v          = i_mm_result[i][c];
                att_next[i][c] = out_t'(acc_v >>> 8);  // drop the probability scale
            end
        end
    end

    // starts fire on the cycle the data arrives, no extra hop
    assign o_mm_start  = ((state == RD_Q) || (state == RD_V)) && i_rd_vld;
    assign o_mm_a      = (state == RD_V) ? p_zext : rd_sext;
    assign o_mm_b      = (state == RD_V) ? rd_sext_t : k_op;
    assign o_sm_start  = (state == QK) && i_mm_done;
    assign o_sm_scores = i_mm_result;

    //////////////////////////////////////////////////////////////////////
    // phase FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state      <= IDLE;
            o_busy     <= 1'b0;
            o_rd_en    <= 1'b0;
            o_rd_sel   <= MAT_K;
            o_att_vld  <= 1'b0;
            o_att_tile <= '0;
        end else begin
            o_rd_en   <= 1'b0;
            o_att_vld <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state    <= RD_K;
                        o_busy   <= 1'b1;
                        o_rd_en  <= 1'b1;
                        o_rd_sel <= MAT_K;
                    end
                end
                RD_K: begin
                    if (i_rd_vld) begin
                        state    <= RD_Q;
                        o_rd_en  <= 1'b1;
                        o_rd_sel <= MAT_Q;
                    end
                end
                RD_Q: begin
                    if (i_rd_vld) begin
                        state <= QK;  // S = Q*K^T launched this cycle
                    end
                end
                QK: begin
                    if (i_mm_done) begin
                        state <= SMAX;
                    end
                end
                SMAX: begin
                    if (i_sm_done) begin
                        state    <= RD_V;
                        o_rd_en  <= 1'b1;
                        o_rd_sel <= MAT_V;
                    end
                end
                RD_V: begin
                    if (i_rd_vld) begin
                        state <= PV;
                    end
                end
                PV: begin
                    if (i_mm_done) begin
                        state      <= DONE;
                        o_att_vld  <= 1'b1;
                        o_att_tile <= att_next;
                    end
                end
                DONE: begin
                    state  <= IDLE;
                    o_busy <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        if (state == RD_K && i_rd_vld) begin
            k_op <= rd_sext;
        end
        if (state == SMAX && i_sm_done) begin
            p_q <= i_sm_probs;
        end
    end

endmodule

//--- hdl/attn_pkg.sv
package attn_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int TILE     = 4;    // tile edge and row count
    localparam int ELEM_W   = 8;    // q, k, v elements
    localparam int PROB_W   = 8;
    localparam int ACC_W    = 20;   // dot product
    localparam int OUT_W    = 16;
    localparam int EXP_BASE = 128;  // weight given to the row max

    //////////////////////////////////////////////////////////////////////
    // element types
    //////////////////////////////////////////////////////////////////////
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ELEM_W:0]   op_t;      // elem sign-ext or prob zero-ext
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic signed [7:0]        score_t;   // scaled, saturated score
    typedef logic        [PROB_W-1:0] prob_t;
    typedef logic signed [OUT_W-1:0]  out_t;
    typedef logic        [1:0]        row_idx_t;

    typedef enum logic [1:0] {
        MAT_Q = 2'd0,
        MAT_K = 2'd1,
        MAT_V = 2'd2
    } mat_sel_t;

    // tiles, row i is index i
    typedef elem_t     [TILE-1:0]           elem_row_t;
    typedef elem_row_t [TILE-1:0]           elem_tile_t;
    typedef op_t       [TILE-1:0][TILE-1:0] op_tile_t;
    typedef acc_t      [TILE-1:0][TILE-1:0] acc_tile_t;
    typedef prob_t     [TILE-1:0][TILE-1:0] prob_tile_t;
    typedef out_t      [TILE-1:0][TILE-1:0] out_tile_t;

    typedef struct packed {
        logic [2:0] scale_shift;  // arithmetic right shift of the scores
        logic       causal;       // mask keys above the diagonal
    } cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        RD_K,
        RD_Q,
        QK,
        SMAX,
        RD_V,
        PV,
        DONE
    } ctrl_state_t;

endpackage

//--- hdl/attn_top.sv
module attn_top
    import attn_pkg::*;
(
    input  logic      I_CLK,
    input  logic      I_RST_N,
    input  logic      i_start,
    input  logic      i_wr_en,
    input  mat_sel_t  i_wr_mat,
    input  row_idx_t  i_wr_row,
    input  elem_row_t i_wr_data,
    input  logic      i_cfg_wr,
    input  cfg_t      i_cfg_data,
    output cfg_t      o_cfg_rdata,
    output logic      o_busy,
    output logic      o_att_vld,
    output out_tile_t o_att_tile
);

    logic       rd_en;
    mat_sel_t   rd_sel;
    logic       rd_vld;
    elem_tile_t rd_tile;
    logic       mm_start;
    op_tile_t   mm_a;
    op_tile_t   mm_b;
    logic       mm_done;
    acc_tile_t  mm_result;
    logic       sm_start;
    acc_tile_t  sm_scores;
    logic       sm_done;
    prob_tile_t sm_probs;

    attn_cfg_regs u_cfg (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .i_cfg_wr   (i_cfg_wr),
        .i_cfg_data (i_cfg_data),
        .i_busy     (o_busy),
        .o_cfg      (o_cfg_rdata)   // readback and softmax steering
    );

    tile_mem u_mem (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .i_wr_en   (i_wr_en),
        .i_wr_mat  (i_wr_mat),
        .i_wr_row  (i_wr_row),
        .i_wr_data (i_wr_data),
        .i_rd_en   (rd_en),
        .i_rd_sel  (rd_sel),
        .o_rd_vld  (rd_vld),
        .o_rd_tile (rd_tile)
    );

    mat_mult_array u_mm (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .i_start  (mm_start),
        .i_a      (mm_a),
        .i_b      (mm_b),
        .o_done   (mm_done),
        .o_result (mm_result)
    );

    row_softmax u_sm (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .i_start  (sm_start),
        .i_scores (sm_scores),
        .i_cfg    (o_cfg_rdata),
        .o_done   (sm_done),
        .o_probs  (sm_probs)
    );

    attn_ctrl u_ctrl (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .i_start     (i_start),
        .o_busy      (o_busy),
        .o_rd_en     (rd_en),
        .o_rd_sel    (rd_sel),
        .i_rd_vld    (rd_vld),
        .i_rd_tile   (rd_tile),
        .o_mm_start  (mm_start),
        .o_mm_a      (mm_a),
        .o_mm_b      (mm_b),
        .i_mm_done   (mm_done),
        .i_mm_result (mm_result),
        .o_sm_start  (sm_start),
        .o_sm_scores (sm_scores),
        .i_sm_done   (sm_done),
        .i_sm_probs  (sm_probs),
        .o_att_vld   (o_att_vld),
        .o_att_tile  (o_att_tile)
    );

endmodule

//--- hdl/mat_mult_array.sv
module mat_mult_array
    import attn_pkg::*;
(
    input  logic      I_CLK,
    input  logic      I_RST_N,
    input  logic      i_start,
    input  op_tile_t  i_a,
    input  op_tile_t  i_b,
    output logic      o_done,
    output acc_tile_t o_result
);

    op_tile_t        a_q;
    op_tile_t        b_q;
    row_idx_t        row;    // next row to write
    logic            run;
    row_idx_t        cur;
    op_t [TILE-1:0]  a_row;
    op_tile_t        b_cur;
    acc_t [TILE-1:0] c_row;

    // row 0 comes straight from the inputs so done lands TILE cycles after start
    assign cur   = i_start ? row_idx_t'(0) : row;
    assign a_row = i_start ? i_a[0] : a_q[row];
    assign b_cur = i_start ? i_b : b_q;

    // c[j] = sum over k of a[cur][k] * b[j][k]
    always_comb begin
        acc_t sum;
        op_t  av;
        op_t  bv;
        for (int j = 0; j < TILE; j++) begin
            sum = '0;
            for (int k = 0; k < TILE; k++) begin
                av  = a_row[k];
                bv  = b_cur[j][k];
                sum = sum + acc_t'(av * bv);
            end
            c_row[j] = sum;
        end
    end

    always_ff @(posedge I_CLK) begin
        if (i_start) begin
            a_q <= i_a;
            b_q <= i_b;
        end
        if (i_start || run) begin
            o_result[cur] <= c_row;
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            run    <= 1'b0;
            row    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                run <= 1'b1;
                row <= row_idx_t'(1);
            end else if (run) begin
                row <= row + 1'b1;  // wraps back to 0 after the last row
                if (row == row_idx_t'(TILE-1)) begin
                    run    <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/row_softmax.sv
module row_softmax
    import attn_pkg::*;
(
    input  logic       I_CLK,
    input  logic       I_RST_N,
    input  logic       i_start,
    input  acc_tile_t  i_scores,
    input  cfg_t       i_cfg,
    output logic       o_done,
    output prob_tile_t o_probs
);

    acc_tile_t        scores_q;
    row_idx_t         row;
    logic             run;
    row_idx_t         cur;    // row being written this cycle
    acc_t [TILE-1:0]  s_row;
    prob_t [TILE-1:0] p_row;

    assign cur   = i_start ? row_idx_t'(0) : row;
    assign s_row = i_start ? i_scores[0] : scores_q[row];

    //////////////////////////////////////////////////////////////////////
    // one row: scale, mask, max, shift exponent, sum, divide
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        acc_t              v;
        acc_t              shifted;
        score_t            s [TILE];
        logic [TILE-1:0]   masked;
        score_t            m;
        logic [8:0]        d;
        logic [PROB_W-1:0] w [TILE];
        logic [9:0]        l;
        logic [15:0]       num;
        m = score_t'(-128);
        for (int j = 0; j < TILE; j++) begin
            v       = s_row[j];
            shifted = v >>> i_cfg.scale_shift;
            if (shifted > acc_t'(127)) begin
                s[j] = score_t'(127);  // saturate high
            end else if (shifted < acc_t'(-128)) begin
                s[j] = score_t'(-128);
            end else begin
                s[j] = score_t'(shifted);
            end
            masked[j] = i_cfg.causal && (j > cur);  // keys after the query
            if (!masked[j] && s[j] > m) begin
                m = s[j];
            end
        end
        l = '0;
        for (int j = 0; j < TILE; j++) begin
            d = m - s[j];  // never negative for unmasked keys
            if (!masked[j] && d < 9'd8) begin
                w[j] = PROB_W'(EXP_BASE >> d);
            end else begin
                w[j] = '0;
            end
            l = l + {2'b00, w[j]};
        end
        // the row max always carries EXP_BASE, so l is never zero
        for (int j = 0; j < TILE; j++) begin
            num      = {8'b0, w[j]} * 16'd255;
            p_row[j] = prob_t'(num / {6'b0, l});
        end
    end

    always_ff @(posedge I_CLK) begin
        if (i_start) begin
            scores_q <= i_scores;
        end
        if (i_start || run) begin
            o_probs[cur] <= p_row;
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            run    <= 1'b0;
            row    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                run <= 1'b1;
                row <= row_idx_t'(1);
            end else if (run) begin
                row <= row + 1'b1;
                if (row == row_idx_t'(TILE-1)) begin
                    run    <= 1'b0;
                    o_done <= 1'b1;  // last row written
                end
            end
        end
    end

endmodule

//--- hdl/tile_mem.sv
module tile_mem
    import attn_pkg::*;
(
    input  logic       I_CLK,
    input  logic       I_RST_N,
    input  logic       i_wr_en,
    input  mat_sel_t   i_wr_mat,
    input  row_idx_t   i_wr_row,
    input  elem_row_t  i_wr_data,
    input  logic       i_rd_en,
    input  mat_sel_t   i_rd_sel,
    output logic       o_rd_vld,
    output elem_tile_t o_rd_tile
);

    elem_tile_t q_tile;
    elem_tile_t k_tile;
    elem_tile_t v_tile;

    always_ff @(posedge I_CLK) begin
        if (i_wr_en) begin
            case (i_wr_mat)
                MAT_Q:   q_tile[i_wr_row] <= i_wr_data;
                MAT_K:   k_tile[i_wr_row] <= i_wr_data;
                MAT_V:   v_tile[i_wr_row] <= i_wr_data;
                default: ;  // unused code, dropped
            endcase
        end
    end

    // whole tile out, one cycle after the request
    always_ff @(posedge I_CLK) begin
        if (i_rd_en) begin
            case (i_rd_sel)
                MAT_Q:   o_rd_tile <= q_tile;
                MAT_K:   o_rd_tile <= k_tile;
                MAT_V:   o_rd_tile <= v_tile;
                default: o_rd_tile <= '0;
            endcase
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            o_rd_vld <= 1'b0;
        end else begin
            o_rd_vld <= i_rd_en;
        end
    end

endmodule

//--- verification/attn_ctrl_chk.sv
module attn_ctrl_chk
    import attn_pkg::*;
(
    input logic        I_CLK,
    input logic        I_RST_N,
    input logic        i_att_vld,
    input logic        i_mm_start,
    input logic        i_sm_start,
    input logic        i_mm_done,
    input logic        i_busy,
    input ctrl_state_t i_state
);

    // result is a single-cycle pulse
    a_vld_pulse: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        i_att_vld |=> !i_att_vld)
        else $error("o_att_vld held high for two cycles");

    a_start_excl: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        !(i_mm_start && i_sm_start))
        else $error("mm_start and sm_start high together");

    // array only finishes inside a multiply phase
    a_done_phase: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        i_mm_done |-> (i_state == QK || i_state == PV))
        else $error("mm_done outside QK or PV");

    a_idle_busy: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (i_state == IDLE) |-> !i_busy)
        else $error("o_busy high in IDLE");

endmodule

bind attn_ctrl attn_ctrl_chk u_chk (
    .I_CLK      (I_CLK),
    .I_RST_N    (I_RST_N),
    .i_att_vld  (o_att_vld),
    .i_mm_start (o_mm_start),
    .i_sm_start (o_sm_start),
    .i_mm_done  (i_mm_done),
    .i_busy     (o_busy),
    .i_state    (state)
);

//--- verification/attn_tb.sv
module attn_tb
    import attn_pkg::*;
();

    logic      I_CLK;
    logic      I_RST_N;
    logic      i_start;
    logic      i_wr_en;
    mat_sel_t  i_wr_mat;
    row_idx_t  i_wr_row;
    elem_row_t i_wr_data;
    logic      i_cfg_wr;
    cfg_t      i_cfg_data;
    cfg_t      o_cfg_rdata;
    logic      o_busy;
    logic      o_att_vld;
    out_tile_t o_att_tile;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    attn_top u_dut (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .i_start     (i_start),
        .i_wr_en     (i_wr_en),
        .i_wr_mat    (i_wr_mat),
        .i_wr_row    (i_wr_row),
        .i_wr_data   (i_wr_data),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_data  (i_cfg_data),
        .o_cfg_rdata (o_cfg_rdata),
        .o_busy      (o_busy),
        .o_att_vld   (o_att_vld),
        .o_att_tile  (o_att_tile)
    );

    initial begin
        I_CLK = 1'b0;
        forever #20 I_CLK = ~I_CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic out_tile_t attention_model(input elem_tile_t q, input elem_tile_t k,
                                                  input elem_tile_t v, input cfg_t c);
        out_tile_t res;
        int        s [TILE];
        int        w [TILE];
        int        p [TILE][TILE];
        int        m;
        int        l;
        int        acc;
        for (int i = 0; i < TILE; i++) begin
            m = -1000;
            for (int j = 0; j < TILE; j++) begin
                acc = 0;
                for (int kk = 0; kk < TILE; kk++) begin
                    acc = acc + int'(q[i][kk]) * int'(k[j][kk]);  // S = Q*K^T
                end
                acc  = acc >>> c.scale_shift;
                s[j] = (acc > 127) ? 127 : ((acc < -128) ? -128 : acc);
                if (!(c.causal && j > i) && s[j] > m) begin
                    m = s[j];
                end
            end
            l = 0;
            for (int j = 0; j < TILE; j++) begin
                if ((c.causal && j > i) || (m - s[j]) >= 8) begin
                    w[j] = 0;  // masked or too far below the max
                end else begin
                    w[j] = EXP_BASE >> (m - s[j]);
                end
                l = l + w[j];
            end
            for (int j = 0; j < TILE; j++) begin
                p[i][j] = (w[j] * 255) / l;
            end
        end
        for (int i = 0; i < TILE; i++) begin
            for (int cc = 0; cc < TILE; cc++) begin
                acc = 0;
                for (int j = 0; j < TILE; j++) begin
                    acc = acc + p[i][j] * int'(v[j][cc]);
                end
                res[i][cc] = out_t'(acc >>> 8);
            end
        end
        return res;
    endfunction

    function automatic elem_tile_t random_tile();
        elem_tile_t t;
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                t[i][j] = elem_t'(int'($urandom_range(15)) - 8);  // -8 .. 7
            end
        end
        return t;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_tile(input string name, input out_tile_t exp, input out_tile_t act);
        checks++;
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                if (exp[i][j] !== act[i][j]) begin
                    errors++;
                    $display("Fail %s att[%0d][%0d] expected %0d actual %0d",
                             name, i, j, exp[i][j], act[i][j]);
                end
            end
        end
    endtask

    task automatic check_cfg(input string name, input cfg_t exp, input cfg_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s cfg expected shift=%0d causal=%0d actual shift=%0d causal=%0d",
                     name, exp.scale_shift, exp.causal, act.scale_shift, act.causal);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus helpers
    //////////////////////////////////////////////////////////////////////
    task automatic load_tile(input mat_sel_t mat, input elem_tile_t t);
        for (int r = 0; r < TILE; r++) begin
            @(posedge I_CLK);
            i_wr_en   <= 1'b1;
            i_wr_mat  <= mat;
            i_wr_row  <= row_idx_t'(r);
            i_wr_data <= t[r];
        end
        @(posedge I_CLK);
        i_wr_en <= 1'b0;
    endtask

    task automatic write_cfg(input cfg_t c);
        @(posedge I_CLK);
        i_cfg_wr   <= 1'b1;
        i_cfg_data <= c;
        @(posedge I_CLK);
        i_cfg_wr   <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge I_CLK);
        i_start <= 1'b1;
        @(posedge I_CLK);
        i_start <= 1'b0;
    endtask

    task automatic wait_result(input string name, output logic ok, output out_tile_t act);
        int n;
        ok  = 1'b0;
        act = '0;
        n   = 0;
        while (!ok && n < 200) begin
            @(negedge I_CLK);
            if (o_att_vld) begin
                ok  = 1'b1;
                act = o_att_tile;
            end
            n++;
        end
        if (!ok) begin
            errors++;
            $display("%s: no result valid within timeout", name);
        end
    endtask

    task automatic wait_busy(input string name, input logic level);
        int n;
        n = 0;
        do begin
            @(negedge I_CLK);
            n++;
        end while (o_busy !== level && n < 200);
        if (o_busy !== level) begin
            errors++;
            $display("%s: o_busy did not reach %0b within timeout", name, level);
        end
    endtask

    // full run with a given config
    task automatic run_tile(input string name, input elem_tile_t q, input elem_tile_t k,
                            input elem_tile_t v, input cfg_t c, output out_tile_t act);
        logic ok;
        load_tile(MAT_Q, q);
        load_tile(MAT_K, k);
        load_tile(MAT_V, v);
        write_cfg(c);
        pulse_start();
        wait_result(name, ok, act);
        wait_busy(name, 1'b0);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - err_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic reset_state();
        int e0;
        e0 = errors;
        @(negedge I_CLK);
        checks++;
        if (o_busy !== 1'b0 || o_att_vld !== 1'b0) begin
            errors++;
            $display("Fail reset busy/vld expected 0/0 actual %0b/%0b", o_busy, o_att_vld);
        end
        check_tile("reset", '0, o_att_tile);
        check_cfg("reset", '0, o_cfg_rdata);
        finish_test("reset", e0);
    endtask

    task automatic identity_attention();
        elem_tile_t idt;
        elem_tile_t v;
        cfg_t       c;
        out_tile_t  act;
        int         e0;
        e0 = errors;
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                idt[i][j] = (i == j) ? elem_t'(16) : elem_t'(0);  // 16 * I
            end
        end
        v = random_tile();
        c = '{scale_shift: 3'd0, causal: 1'b0};
        run_tile("identity", idt, idt, v, c, act);
        check_tile("identity", attention_model(idt, idt, v, c), act);
        finish_test("identity", e0);
    endtask

    task automatic random_tiles();
        elem_tile_t q;
        elem_tile_t k;
        elem_tile_t v;
        cfg_t       c;
        out_tile_t  act;
        string      name;
        int         e0;
        for (int r = 0; r < 5; r++) begin
            e0   = errors;
            name = $sformatf("random_%0d", r);
            q    = random_tile();
            k    = random_tile();
            v    = random_tile();
            c    = '{scale_shift: 3'($urandom_range(4)), causal: 1'b0};
            run_tile(name, q, k, v, c, act);
            check_tile(name, attention_model(q, k, v, c), act);
            finish_test(name, e0);
        end
    endtask

    task automatic causal_mask();
        elem_tile_t q;
        elem_tile_t k;
        elem_tile_t v;
        cfg_t       c;
        out_tile_t  exp;
        out_tile_t  act;
        int         e0;
        e0 = errors;
        q  = random_tile();
        k  = random_tile();
        v  = random_tile();
        c  = '{scale_shift: 3'd1, causal: 1'b1};
        exp = attention_model(q, k, v, c);
        for (int cc = 0; cc < TILE; cc++) begin
            exp[0][cc] = out_t'((255 * int'(v[0][cc])) >>> 8);  // only key 0 visible
        end
        run_tile("causal", q, k, v, c, act);
        check_tile("causal", exp, act);
        finish_test("causal", e0);
    endtask

    task automatic cfg_lock();
        elem_tile_t q;
        elem_tile_t k;
        elem_tile_t v;
        cfg_t       c_old;
        cfg_t       c_new;
        out_tile_t  act;
        logic       ok;
        int         e0;
        e0    = errors;
        q     = random_tile();
        k     = random_tile();
        v     = random_tile();
        c_old = '{scale_shift: 3'd3, causal: 1'b0};
        c_new = '{scale_shift: 3'd1, causal: 1'b1};
        load_tile(MAT_Q, q);
        load_tile(MAT_K, k);
        load_tile(MAT_V, v);
        write_cfg(c_old);
        pulse_start();
        wait_busy("cfg_lock", 1'b1);
        write_cfg(c_new);  // lands mid run
        wait_result("cfg_lock", ok, act);
        if (ok) begin
            check_tile("cfg_lock", attention_model(q, k, v, c_old), act);
        end
        wait_busy("cfg_lock", 1'b0);
        check_cfg("cfg_lock", c_old, o_cfg_rdata);
        write_cfg(c_new);
        @(negedge I_CLK);
        check_cfg("cfg_lock", c_new, o_cfg_rdata);
        finish_test("cfg_lock", e0);
    endtask

    task automatic start_while_busy();
        elem_tile_t q;
        elem_tile_t k;
        elem_tile_t v;
        cfg_t       c;
        out_tile_t  act;
        int         vld_cnt;
        int         n;
        int         e0;
        e0      = errors;
        vld_cnt = 0;
        n       = 0;
        act     = '0;
        q       = random_tile();
        k       = random_tile();
        v       = random_tile();
        c       = '{scale_shift: 3'd2, causal: 1'b0};
        load_tile(MAT_Q, q);
        load_tile(MAT_K, k);
        load_tile(MAT_V, v);
        write_cfg(c);
        pulse_start();
        wait_busy("start_busy", 1'b1);
        pulse_start();  // dropped while busy
        do begin
            @(negedge I_CLK);
            if (o_att_vld) begin
                vld_cnt++;
                act = o_att_tile;
            end
            n++;
        end while (o_busy && n < 200);
        if (o_busy) begin
            errors++;
            $display("start_busy: o_busy did not fall within timeout");
        end
        // nothing may follow once the run is over
        for (int i = 0; i < 30; i++) begin
            @(negedge I_CLK);
            if (o_att_vld || o_busy) begin
                vld_cnt += o_att_vld ? 1 : 0;
                if (o_busy) begin
                    errors++;
                    $display("start_busy: second start began a new run");
                end
            end
        end
        checks++;
        if (vld_cnt != 1) begin
            errors++;
            $display("Fail start_busy vld pulses expected 1 actual %0d", vld_cnt);
        end
        check_tile("start_busy", attention_model(q, k, v, c), act);
        finish_test("start_busy", e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(79));
        I_RST_N    <= 1'b0;
        i_start    <= 1'b0;
        i_wr_en    <= 1'b0;
        i_wr_mat   <= MAT_Q;
        i_wr_row   <= '0;
        i_wr_data  <= '0;
        i_cfg_wr   <= 1'b0;
        i_cfg_data <= '0;
        repeat (2) @(posedge I_CLK);
        I_RST_N <= 1'b1;

        reset_state();
        identity_attention();
        random_tiles();
        causal_mask();
        cfg_lock();
        start_while_busy();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
